// File: alu_rs_unit.f
rv32i_types.sv
alu.sv
cmp.sv
alu_rs.sv
cdb_stage.sv
alu_rs_unit.sv
tb_alu_rs_unit.sv

// File: tb_alu_rs_unit.sv
`timescale 1ns/1ns

module tb_alu_rs_unit;

  localparam int ALU_RS_DEPTH = 3;
  localparam int ROB_DEPTH    = 3;
  localparam int CDB_SIZE     = 3;
  localparam int NUM_TAGS     = 2 ** ROB_DEPTH;
  localparam int NUM_ENT      = 2 ** ALU_RS_DEPTH;

  // test lengths in cycles
  localparam int LAT_LEN   = 48;
  localparam int RDY_LEN   = 400;
  localparam int WAIT_LEN  = 400;
  localparam int FILL_LEN  = 40;
  localparam int FLUSH_LEN = 80;
  localparam int TOTAL_LEN = LAT_LEN + RDY_LEN + WAIT_LEN + FILL_LEN + FLUSH_LEN;

  logic                               clk;
  logic                               arst_n;
  logic                               flush;
  logic                               issue;
  logic [6:0]                         opcode;
  logic [2:0]                         funct3;
  logic [6:0]                         funct7;
  logic [31:0]                        imm;
  logic [31:0]                        pc;
  logic [ROB_DEPTH-1:0]               target_rob;
  logic                               rs1_regfile_ready;
  logic [31:0]                        rs1_regfile_v;
  logic [ROB_DEPTH-1:0]               rs1_regfile_rob;
  logic                               rs2_regfile_ready;
  logic [31:0]                        rs2_regfile_v;
  logic [ROB_DEPTH-1:0]               rs2_regfile_rob;
  logic                               rs1_rob_ready;
  logic [31:0]                        rs1_rob_v;
  logic                               rs2_rob_ready;
  logic [31:0]                        rs2_rob_v;
  logic [CDB_SIZE-1:0]                cdb_valid;
  logic [CDB_SIZE-1:0][ROB_DEPTH-1:0] cdb_rob;
  logic [CDB_SIZE-1:0][31:0]          cdb_rd_v;
  logic                               rs_full;
  logic                               out_valid;
  logic [31:0]                        out_f;
  logic [ROB_DEPTH-1:0]               out_rob;

  // reference model state indexed by rob tag
  logic [31:0]          lfsr;
  string                test_name;
  logic [NUM_TAGS-1:0]  inflight;
  int                   inflight_cnt;
  logic [31:0]          exp_val [NUM_TAGS];
  logic [NUM_TAGS-1:0]  wait1;
  logic [NUM_TAGS-1:0]  wait2;
  logic [ROB_DEPTH-1:0] src1 [NUM_TAGS];
  logic [ROB_DEPTH-1:0] src2 [NUM_TAGS];
  // producers that still owe a broadcast
  logic [NUM_TAGS-1:0]  prod_pending;
  logic [31:0]          prod_val [NUM_TAGS];
  logic [ROB_DEPTH-1:0] last_tag;

  alu_rs_unit i_alu_rs_unit (
    .clk               (clk),
    .arst_n            (arst_n),
    .flush             (flush),
    .issue             (issue),
    .opcode            (opcode),
    .funct3            (funct3),
    .funct7            (funct7),
    .imm               (imm),
    .pc                (pc),
    .target_rob        (target_rob),
    .rs1_regfile_ready (rs1_regfile_ready),
    .rs1_regfile_v     (rs1_regfile_v),
    .rs1_regfile_rob   (rs1_regfile_rob),
    .rs2_regfile_ready (rs2_regfile_ready),
    .rs2_regfile_v     (rs2_regfile_v),
    .rs2_regfile_rob   (rs2_regfile_rob),
    .rs1_rob_ready     (rs1_rob_ready),
    .rs1_rob_v         (rs1_rob_v),
    .rs2_rob_ready     (rs2_rob_ready),
    .rs2_rob_v         (rs2_rob_v),
    .cdb_valid         (cdb_valid),
    .cdb_rob           (cdb_rob),
    .cdb_rd_v          (cdb_rd_v),
    .rs_full           (rs_full),
    .out_valid         (out_valid),
    .out_f             (out_f),
    .out_rob           (out_rob)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rnd_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
    end
    return r;
  endfunction

  // rv32i integer semantics
  function automatic logic [31:0] expected_result(
    input logic [6:0]  op,
    input logic [2:0]  f3,
    input logic [6:0]  f7,
    input logic [31:0] a,
    input logic [31:0] b
  );
    logic [31:0] r;
    case (f3)
      rv32i_types::add_funct3: begin
        if (op == rv32i_types::reg_opcode && f7[5]) begin
          r = a - b;
        end else begin
          r = a + b;
        end
      end
      rv32i_types::sll_funct3:  r = a << b[4:0];
      rv32i_types::slt_funct3:  r = {31'b0, ($signed(a) < $signed(b))};
      rv32i_types::sltu_funct3: r = {31'b0, (a < b)};
      rv32i_types::xor_funct3:  r = a ^ b;
      rv32i_types::sr_funct3: begin
        if (f7[5]) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      rv32i_types::or_funct3:   r = a | b;
      default:                  r = a & b;
    endcase
    // lui and auipc are plain adds of their operands
    if (op == rv32i_types::lui_opcode || op == rv32i_types::auipc_opcode) begin
      r = a + b;
    end
    return r;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected %h actual %h", test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_output();
    if (out_valid === 1'b1) begin
      check_equal("output tag in flight", 32'd1, 32'(inflight[out_rob]));
      check_equal("rs1 woken before output", 32'd0, 32'(wait1[out_rob]));
      check_equal("rs2 woken before output", 32'd0, 32'(wait2[out_rob]));
      check_equal("out_f", exp_val[out_rob], out_f);
      inflight[out_rob] = 1'b0;
      inflight_cnt--;
    end else begin
      check_equal("out_valid known", 32'd0, 32'(out_valid));
    end
  endtask

  // outputs are checked on the falling edge, then inputs go idle
  task automatic step_cycle();
    int j;
    @(negedge clk);
    check_output();
    issue     = 1'b0;
    flush     = 1'b0;
    cdb_valid = '0;
    for (j = 0; j < CDB_SIZE; j++) begin
      cdb_rob[j]  = ROB_DEPTH'(rnd_bits(ROB_DEPTH));
      cdb_rd_v[j] = rnd_bits(32);
    end
  endtask

  function automatic logic can_issue();
    return (rs_full === 1'b0) && (inflight_cnt < NUM_TAGS);
  endfunction

  // mode 0 ready, 1 maybe waiting, 2 always waiting
  task automatic pick_operand(
    input  int                   mode,
    output logic                 rf_rdy,
    output logic [31:0]          rf_v,
    output logic [ROB_DEPTH-1:0] rf_rob,
    output logic                 rob_rdy,
    output logic [31:0]          rob_v,
    output logic [31:0]          val,
    output logic                 waits
  );
    logic [1:0] src;
    rf_v   = rnd_bits(32);
    rob_v  = rnd_bits(32);
    rf_rob = ROB_DEPTH'(rnd_bits(ROB_DEPTH));
    src    = 2'(rnd_bits(2));
    waits  = (mode == 2) || (mode == 1 && src == 2'd3);
    if (waits) begin
      rf_rdy  = 1'b0;
      rob_rdy = 1'b0;
      // a producer already owed keeps its value
      if (!prod_pending[rf_rob]) begin
        prod_val[rf_rob]     = rnd_bits(32);
        prod_pending[rf_rob] = 1'b1;
      end
      val = prod_val[rf_rob];
    end else if (src == 2'd0) begin
      rf_rdy  = 1'b1;
      rob_rdy = 1'b0;
      val     = rf_v;
    end else if (src == 2'd1) begin
      rf_rdy  = 1'b0;
      rob_rdy = 1'b1;
      val     = rob_v;
    end else begin
      rf_rdy  = 1'b1;
      rob_rdy = 1'b1;
      val     = rf_v;
    end
  endtask

  task automatic issue_random(input logic arith, input int mode);
    logic [ROB_DEPTH-1:0] t;
    logic [6:0]           op;
    logic [31:0]          v1;
    logic [31:0]          v2;
    logic                 w1;
    logic                 w2;
    logic [31:0]          a;
    logic [31:0]          b;
    t = ROB_DEPTH'(rnd_bits(ROB_DEPTH));
    while (inflight[t]) begin
      t = t + 1'b1;
    end
    if (arith) begin
      op = rnd_bits(1) ? rv32i_types::reg_opcode : rv32i_types::imm_opcode;
    end else begin
      op = rnd_bits(1) ? rv32i_types::lui_opcode : rv32i_types::auipc_opcode;
    end
    funct3 = 3'(rnd_bits(3));
    funct7 = rnd_bits(1) ? 7'h20 : 7'h00;
    imm    = rnd_bits(32);
    pc     = rnd_bits(32);
    pick_operand(arith ? mode : 0, rs1_regfile_ready, rs1_regfile_v, rs1_regfile_rob,
                 rs1_rob_ready, rs1_rob_v, v1, w1);
    pick_operand((op == rv32i_types::reg_opcode) ? ((mode == 2) ? 1 : mode) : 0,
                 rs2_regfile_ready, rs2_regfile_v, rs2_regfile_rob,
                 rs2_rob_ready, rs2_rob_v, v2, w2);
    case (op)
      rv32i_types::lui_opcode: begin
        a = 32'd0;
        b = imm;
      end
      rv32i_types::auipc_opcode: begin
        a = pc;
        b = imm;
      end
      rv32i_types::imm_opcode: begin
        a = v1;
        b = imm;
      end
      default: begin
        a = v1;
        b = v2;
      end
    endcase
    opcode       = op;
    target_rob   = t;
    issue        = 1'b1;
    exp_val[t]   = expected_result(op, funct3, funct7, a, b);
    inflight[t]  = 1'b1;
    inflight_cnt++;
    wait1[t]     = w1;
    wait2[t]     = w2;
    src1[t]      = rs1_regfile_rob;
    src2[t]      = rs2_regfile_rob;
    last_tag     = t;
  endtask

  // one owed producer goes out on a random lane
  task automatic broadcast_pending();
    logic [ROB_DEPTH-1:0] p;
    int                   lane;
    int                   t;
    if (prod_pending != '0) begin
      p = ROB_DEPTH'(rnd_bits(ROB_DEPTH));
      while (!prod_pending[p]) begin
        p = p + 1'b1;
      end
      lane            = int'(rnd_bits(2)) % CDB_SIZE;
      cdb_valid[lane] = 1'b1;
      cdb_rob[lane]   = p;
      cdb_rd_v[lane]  = prod_val[p];
      prod_pending[p] = 1'b0;
      for (t = 0; t < NUM_TAGS; t++) begin
        if (wait1[t] && src1[t] == p) begin
          wait1[t] = 1'b0;
        end
        if (wait2[t] && src2[t] == p) begin
          wait2[t] = 1'b0;
        end
      end
    end
  endtask

  task automatic drain_unit();
    while (inflight_cnt > 0) begin
      step_cycle();
      if (rnd_bits(1)) begin
        broadcast_pending();
      end
    end
  endtask

  initial begin
    int i;
    lfsr              = 32'h238d;
    test_name         = "reset";
    arst_n            = 1'b0;
    flush             = 1'b0;
    issue             = 1'b0;
    opcode            = '0;
    funct3            = '0;
    funct7            = '0;
    imm               = '0;
    pc                = '0;
    target_rob        = '0;
    rs1_regfile_ready = 1'b0;
    rs1_regfile_v     = '0;
    rs1_regfile_rob   = '0;
    rs2_regfile_ready = 1'b0;
    rs2_regfile_v     = '0;
    rs2_regfile_rob   = '0;
    rs1_rob_ready     = 1'b0;
    rs1_rob_v         = '0;
    rs2_rob_ready     = 1'b0;
    rs2_rob_v         = '0;
    cdb_valid         = '0;
    cdb_rob           = '0;
    cdb_rd_v          = '0;
    inflight          = '0;
    inflight_cnt      = 0;
    wait1             = '0;
    wait2             = '0;
    prod_pending      = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    step_cycle();
    check_equal("rs_full", 32'd0, 32'(rs_full));
    check_equal("out_valid", 32'd0, 32'(out_valid));
    check_equal("out_f", 32'd0, out_f);
    check_equal("out_rob", 32'd0, 32'(out_rob));

    // lone lui and auipc take exactly two edges
    test_name = "lui_auipc";
    for (i = 0; i < LAT_LEN / 3; i++) begin
      step_cycle();
      issue_random(1'b0, 0);
      step_cycle();
      check_equal("out_valid one edge after issue", 32'd0, 32'(out_valid));
      step_cycle();
      check_equal("out_valid two edges after issue", 32'd1, 32'(out_valid));
      check_equal("out_rob", 32'(last_tag), 32'(out_rob));
    end

    test_name = "ready_ops";
    for (i = 0; i < RDY_LEN; i++) begin
      step_cycle();
      if (can_issue() && rnd_bits(1)) begin
        issue_random(rnd_bits(2) != 0, 0);
      end
    end
    drain_unit();

    test_name = "cdb_wakeup";
    for (i = 0; i < WAIT_LEN; i++) begin
      step_cycle();
      if (can_issue() && rnd_bits(1)) begin
        issue_random(rnd_bits(2) != 0, 1);
      end
      if (rnd_bits(1)) begin
        broadcast_pending();
      end
    end
    drain_unit();

    test_name = "fill";
    for (i = 0; i < NUM_ENT; i++) begin
      step_cycle();
      check_equal("rs_full while filling", 32'd0, 32'(rs_full));
      issue_random(1'b1, 2);
    end
    step_cycle();
    check_equal("rs_full when full", 32'd1, 32'(rs_full));
    drain_unit();
    check_equal("rs_full after drain", 32'd0, 32'(rs_full));

    test_name = "flush";
    for (i = 0; i < NUM_ENT; i++) begin
      step_cycle();
      issue_random(1'b1, 2);
    end
    step_cycle();
    check_equal("rs_full before flush", 32'd1, 32'(rs_full));
    flush        = 1'b1;
    inflight     = '0;
    inflight_cnt = 0;
    prod_pending = '0;
    step_cycle();
    check_equal("rs_full after flush", 32'd0, 32'(rs_full));
    check_equal("out_valid after flush", 32'd0, 32'(out_valid));
    check_equal("out_f after flush", 32'd0, out_f);
    check_equal("out_rob after flush", 32'd0, 32'(out_rob));
    // stale tags on the bus must wake nothing
    for (i = 0; i < FLUSH_LEN / 2; i++) begin
      step_cycle();
      cdb_valid = CDB_SIZE'(rnd_bits(CDB_SIZE));
    end
    for (i = 0; i < FLUSH_LEN / 2; i++) begin
      step_cycle();
      if (can_issue() && rnd_bits(1)) begin
        issue_random(1'b1, 1);
      end
      if (rnd_bits(1)) begin
        broadcast_pending();
      end
    end
    drain_unit();

    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    repeat (TOTAL_LEN * 40) @(posedge clk);
    $display("Timeout: the unit did not finish the tests in time");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

// File: alu_rs_unit.sv
`timescale 1ns/1ns

module alu_rs_unit #(
  parameter int ALU_RS_DEPTH = 3,
  parameter int ROB_DEPTH    = 3,
  parameter int CDB_SIZE     = 3
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                flush,
  input  logic                                issue,
  input  logic [6:0]                          opcode,
  input  logic [2:0]                          funct3,
  input  logic [6:0]                          funct7,
  input  logic [31:0]                         imm,
  input  logic [31:0]                         pc,
  input  logic [ROB_DEPTH-1:0]                target_rob,
  input  logic                                rs1_regfile_ready,
  input  logic [31:0]                         rs1_regfile_v,
  input  logic [ROB_DEPTH-1:0]                rs1_regfile_rob,
  input  logic                                rs2_regfile_ready,
  input  logic [31:0]                         rs2_regfile_v,
  input  logic [ROB_DEPTH-1:0]                rs2_regfile_rob,
  input  logic                                rs1_rob_ready,
  input  logic [31:0]                         rs1_rob_v,
  input  logic                                rs2_rob_ready,
  input  logic [31:0]                         rs2_rob_v,
  input  logic [CDB_SIZE-1:0]                 cdb_valid,
  input  logic [CDB_SIZE-1:0][ROB_DEPTH-1:0]  cdb_rob,
  input  logic [CDB_SIZE-1:0][31:0]           cdb_rd_v,
  output logic                                rs_full,
  output logic                                out_valid,
  output logic [31:0]                         out_f,
  output logic [ROB_DEPTH-1:0]                out_rob
);

  logic                 exe_valid;
  logic [ROB_DEPTH-1:0] exe_rob;
  logic [31:0]          exe_a;
  logic [31:0]          exe_b;
  rv32i_types::exe_op_u exe_op;
  logic                 exe_is_cmp;
  logic [31:0]          alu_f;
  logic                 cmp_f;

  alu_rs #(
    .ALU_RS_DEPTH (ALU_RS_DEPTH),
    .ROB_DEPTH    (ROB_DEPTH),
    .CDB_SIZE     (CDB_SIZE)
  ) i_alu_rs (
    .clk               (clk),
    .arst_n            (arst_n),
    .flush             (flush),
    .issue             (issue),
    .opcode            (opcode),
    .funct3            (funct3),
    .funct7            (funct7),
    .imm               (imm),
    .pc                (pc),
    .target_rob        (target_rob),
    .rs1_regfile_ready (rs1_regfile_ready),
    .rs1_regfile_v     (rs1_regfile_v),
    .rs1_regfile_rob   (rs1_regfile_rob),
    .rs2_regfile_ready (rs2_regfile_ready),
    .rs2_regfile_v     (rs2_regfile_v),
    .rs2_regfile_rob   (rs2_regfile_rob),
    .rs1_rob_ready     (rs1_rob_ready),
    .rs1_rob_v         (rs1_rob_v),
    .rs2_rob_ready     (rs2_rob_ready),
    .rs2_rob_v         (rs2_rob_v),
    .cdb_valid         (cdb_valid),
    .cdb_rob           (cdb_rob),
    .cdb_rd_v          (cdb_rd_v),
    .rs_full           (rs_full),
    .exe_valid         (exe_valid),
    .exe_rob           (exe_rob),
    .exe_a             (exe_a),
    .exe_b             (exe_b),
    .exe_op            (exe_op),
    .exe_is_cmp        (exe_is_cmp)
  );

  // both units see the same operands
  alu i_alu (
    .a  (exe_a),
    .b  (exe_b),
    .op (exe_op),
    .f  (alu_f)
  );

  cmp i_cmp (
    .a  (exe_a),
    .b  (exe_b),
    .op (exe_op),
    .lt (cmp_f)
  );

  cdb_stage #(
    .ROB_DEPTH (ROB_DEPTH)
  ) i_cdb_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .exe_valid  (exe_valid),
    .exe_is_cmp (exe_is_cmp),
    .exe_rob    (exe_rob),
    .alu_f      (alu_f),
    .cmp_f      (cmp_f),
    .out_valid  (out_valid),
    .out_f      (out_f),
    .out_rob    (out_rob)
  );

endmodule

// File: cdb_stage.sv
`timescale 1ns/1ns

module cdb_stage #(
  parameter int ROB_DEPTH = 3
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 flush,
  input  logic                 exe_valid,
  input  logic                 exe_is_cmp,
  input  logic [ROB_DEPTH-1:0] exe_rob,
  input  logic [31:0]          alu_f,
  input  logic                 cmp_f,
  output logic                 out_valid,
  output logic [31:0]          out_f,
  output logic [ROB_DEPTH-1:0] out_rob
);

  logic [31:0] res;

  // slt result is a single bit
  assign res = exe_is_cmp ? {31'b0, cmp_f} : alu_f;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_f     <= '0;
      out_rob   <= '0;
    end else if (flush) begin
      out_valid <= 1'b0;
      out_f     <= '0;
      out_rob   <= '0;
    end else begin
      out_valid <= exe_valid;
      // hold the last broadcast while idle
      if (exe_valid) begin
        out_f   <= res;
        out_rob <= exe_rob;
      end
    end
  end

  // a broadcast carries a known result and tag
  a_valid_src: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> $past(exe_valid) && !$isunknown({out_rob, out_f}));

endmodule

// File: alu_rs.sv
`timescale 1ns/1ns

module alu_rs #(
  parameter int ALU_RS_DEPTH = 3,
  parameter int ROB_DEPTH    = 3,
  parameter int CDB_SIZE     = 3
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                flush,

  // issue side
  input  logic                                issue,
  input  logic [6:0]                          opcode,
  input  logic [2:0]                          funct3,
  input  logic [6:0]                          funct7,
  input  logic [31:0]                         imm,
  input  logic [31:0]                         pc,
  input  logic [ROB_DEPTH-1:0]                target_rob,

  input  logic                                rs1_regfile_ready,
  input  logic [31:0]                         rs1_regfile_v,
  input  logic [ROB_DEPTH-1:0]                rs1_regfile_rob,
  input  logic                                rs2_regfile_ready,
  input  logic [31:0]                         rs2_regfile_v,
  input  logic [ROB_DEPTH-1:0]                rs2_regfile_rob,
  input  logic                                rs1_rob_ready,
  input  logic [31:0]                         rs1_rob_v,
  input  logic                                rs2_rob_ready,
  input  logic [31:0]                         rs2_rob_v,

  // snooped broadcasts
  input  logic [CDB_SIZE-1:0]                 cdb_valid,
  input  logic [CDB_SIZE-1:0][ROB_DEPTH-1:0]  cdb_rob,
  input  logic [CDB_SIZE-1:0][31:0]           cdb_rd_v,

  output logic                                rs_full,

  // to the datapath
  output logic                                exe_valid,
  output logic [ROB_DEPTH-1:0]                exe_rob,
  output logic [31:0]                         exe_a,
  output logic [31:0]                         exe_b,
  output rv32i_types::exe_op_u                exe_op,
  output logic                                exe_is_cmp
);

  localparam int NUM_ENT = 2 ** ALU_RS_DEPTH;

  // control state
  logic [NUM_ENT-1:0]      busy;
  logic [ALU_RS_DEPTH-1:0] counter;

  // per-entry payload
  logic [6:0]              ent_opcode  [NUM_ENT];
  logic [2:0]              ent_funct3  [NUM_ENT];
  logic [6:0]              ent_funct7  [NUM_ENT];
  logic [NUM_ENT-1:0]      ent_rs1_rdy;
  logic [NUM_ENT-1:0]      ent_rs2_rdy;
  logic [31:0]             ent_rs1_v   [NUM_ENT];
  logic [31:0]             ent_rs2_v   [NUM_ENT];
  logic [ROB_DEPTH-1:0]    ent_rs1_rob [NUM_ENT];
  logic [ROB_DEPTH-1:0]    ent_rs2_rob [NUM_ENT];
  logic [ROB_DEPTH-1:0]    ent_target  [NUM_ENT];

  logic                    iss_we;
  logic [ALU_RS_DEPTH-1:0] alloc_idx;
  // {ready, value} of each operand at issue
  logic [32:0]             iss_a;
  logic [32:0]             iss_b;

  logic [NUM_ENT-1:0]      rdy_vec;
  logic                    pop;
  logic [ALU_RS_DEPTH-1:0] pop_idx;

  // regfile first, then rob, then a same-cycle broadcast
  function automatic logic [32:0] src_pick(
    input logic                 rf_rdy,
    input logic [31:0]          rf_v,
    input logic                 rob_rdy,
    input logic [31:0]          rob_v,
    input logic [ROB_DEPTH-1:0] tag
  );
    logic [32:0] r;
    r = '0;
    if (rf_rdy) begin
      r = {1'b1, rf_v};
    end else if (rob_rdy) begin
      r = {1'b1, rob_v};
    end else begin
      for (int j = 0; j < CDB_SIZE; j++) begin
        if (cdb_valid[j] && cdb_rob[j] == tag) begin
          r = {1'b1, cdb_rd_v[j]};
        end
      end
    end
    return r;
  endfunction

  assign rs_full = &busy;
  assign iss_we  = issue && !rs_full;

  // lowest free slot
  always_comb begin
    alloc_idx = '0;
    for (int i = NUM_ENT - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        alloc_idx = ALU_RS_DEPTH'(i);
      end
    end
  end

  // operand sources per opcode
  always_comb begin
    case (opcode)
      rv32i_types::lui_opcode: begin
        iss_a = {1'b1, 32'b0};
        iss_b = {1'b1, imm};
      end
      rv32i_types::auipc_opcode: begin
        iss_a = {1'b1, pc};
        iss_b = {1'b1, imm};
      end
      rv32i_types::imm_opcode: begin
        iss_a = src_pick(rs1_regfile_ready, rs1_regfile_v, rs1_rob_ready, rs1_rob_v,
                         rs1_regfile_rob);
        iss_b = {1'b1, imm};
      end
      default: begin
        iss_a = src_pick(rs1_regfile_ready, rs1_regfile_v, rs1_rob_ready, rs1_rob_v,
                         rs1_regfile_rob);
        iss_b = src_pick(rs2_regfile_ready, rs2_regfile_v, rs2_rob_ready, rs2_rob_v,
                         rs2_regfile_rob);
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= '0;
      counter <= '0;
    end else if (flush) begin
      busy    <= '0;
      counter <= '0;
    end else begin
      if (iss_we) begin
        busy[alloc_idx] <= 1'b1;
      end
      // the pop slot is busy, so it never matches alloc_idx
      if (pop) begin
        busy[pop_idx] <= 1'b0;
        counter       <= pop_idx + 1'b1;
      end
    end
  end

  // capture and cdb wakeup
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_ENT; i++) begin
      if (iss_we && alloc_idx == ALU_RS_DEPTH'(i)) begin
        ent_opcode[i]  <= opcode;
        ent_funct3[i]  <= funct3;
        ent_funct7[i]  <= funct7;
        ent_target[i]  <= target_rob;
        ent_rs1_rob[i] <= rs1_regfile_rob;
        ent_rs2_rob[i] <= rs2_regfile_rob;
        ent_rs1_rdy[i] <= iss_a[32];
        ent_rs1_v[i]   <= iss_a[31:0];
        ent_rs2_rdy[i] <= iss_b[32];
        ent_rs2_v[i]   <= iss_b[31:0];
      end else if (busy[i]) begin
        for (int j = 0; j < CDB_SIZE; j++) begin
          if (cdb_valid[j] && !ent_rs1_rdy[i] && cdb_rob[j] == ent_rs1_rob[i]) begin
            ent_rs1_rdy[i] <= 1'b1;
            ent_rs1_v[i]   <= cdb_rd_v[j];
          end
          if (cdb_valid[j] && !ent_rs2_rdy[i] && cdb_rob[j] == ent_rs2_rob[i]) begin
            ent_rs2_rdy[i] <= 1'b1;
            ent_rs2_v[i]   <= cdb_rd_v[j];
          end
        end
      end
    end
  end

  assign rdy_vec = busy & ent_rs1_rdy & ent_rs2_rdy;

  // round robin starting after the last pop
  always_comb begin
    logic [ALU_RS_DEPTH-1:0] idx;
    pop     = 1'b0;
    pop_idx = '0;
    for (int i = 0; i < NUM_ENT; i++) begin
      idx = counter + ALU_RS_DEPTH'(i);
      if (!pop && rdy_vec[idx]) begin
        pop     = 1'b1;
        pop_idx = idx;
      end
    end
  end

  assign exe_valid = pop;
  assign exe_rob   = ent_target[pop_idx];
  assign exe_a     = ent_rs1_v[pop_idx];
  assign exe_b     = ent_rs2_v[pop_idx];

  // op decode of the selected entry
  always_comb begin
    exe_op.alu = rv32i_types::add_alu_op;
    exe_is_cmp = 1'b0;
    if (ent_opcode[pop_idx] == rv32i_types::imm_opcode ||
        ent_opcode[pop_idx] == rv32i_types::reg_opcode) begin
      case (ent_funct3[pop_idx])
        rv32i_types::slt_funct3: begin
          exe_is_cmp = 1'b1;
          exe_op.cmp = rv32i_types::blt_cmp_op;
        end
        rv32i_types::sltu_funct3: begin
          exe_is_cmp = 1'b1;
          exe_op.cmp = rv32i_types::bltu_cmp_op;
        end
        rv32i_types::sr_funct3: begin
          exe_op.alu = ent_funct7[pop_idx][5] ? rv32i_types::sra_alu_op
                                              : rv32i_types::srl_alu_op;
        end
        rv32i_types::add_funct3: begin
          // addi has no subtract form
          if (ent_opcode[pop_idx] == rv32i_types::reg_opcode && ent_funct7[pop_idx][5]) begin
            exe_op.alu = rv32i_types::sub_alu_op;
          end
        end
        default: begin
          exe_op.alu = rv32i_types::alu_op_t'(ent_funct3[pop_idx]);
        end
      endcase
    end
  end

  a_no_issue_full: assert property (@(posedge clk) disable iff (!arst_n)
    issue |-> !rs_full);

  // a slot frees only after it was ready, and never two at once
  a_one_pop: assert property (@(posedge clk) disable iff (!arst_n)
    !$past(flush) |-> $onehot0($past(busy) & ~busy) &&
                      (($past(busy) & ~busy & ~$past(rdy_vec)) == '0));

  // a resident entry keeps its tag until it pops
  for (genvar g = 0; g < NUM_ENT; g++) begin : g_tag_chk
    a_tag_stable: assert property (@(posedge clk) disable iff (!arst_n)
      busy[g] && $past(busy[g]) |-> $stable(ent_target[g]));
  end

endmodule

// File: cmp.sv
`timescale 1ns/1ns

module cmp (
  input  logic [31:0]          a,
  input  logic [31:0]          b,
  input  rv32i_types::exe_op_u op,
  output logic                 lt
);

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  // any other code falls back to the signed compare
  always_comb begin
    case (op.cmp)
      rv32i_types::bltu_cmp_op: begin
        lt = lt_unsigned;
      end
      rv32i_types::blt_cmp_op: begin
        lt = lt_signed;
      end
      default: begin
        lt = lt_signed;
      end
    endcase
  end

endmodule

// File: alu.sv
`timescale 1ns/1ns

module alu (
  input  logic [31:0]          a,
  input  logic [31:0]          b,
  input  rv32i_types::exe_op_u op,
  output logic [31:0]          f
);

  logic [4:0] shamt;

  // only the low five bits shift
  assign shamt = b[4:0];

  always_comb begin
    case (op.alu)
      rv32i_types::add_alu_op: begin
        f = a + b;
      end
      rv32i_types::sub_alu_op: begin
        f = a - b;
      end
      rv32i_types::sll_alu_op: begin
        f = a << shamt;
      end
      rv32i_types::srl_alu_op: begin
        f = a >> shamt;
      end
      rv32i_types::sra_alu_op: begin
        f = unsigned'($signed(a) >>> shamt);
      end
      rv32i_types::xor_alu_op: begin
        f = a ^ b;
      end
      rv32i_types::or_alu_op: begin
        f = a | b;
      end
      rv32i_types::and_alu_op: begin
        f = a & b;
      end
      default: begin
        f = '0;
      end
    endcase
  end

endmodule

// File: rv32i_types.sv
package rv32i_types;

  // rv32i major opcodes handled by this unit
  localparam logic [6:0] lui_opcode   = 7'b0110111;
  localparam logic [6:0] auipc_opcode = 7'b0010111;
  localparam logic [6:0] imm_opcode   = 7'b0010011;
  localparam logic [6:0] reg_opcode   = 7'b0110011;

  // integer funct3 fields
  localparam logic [2:0] add_funct3  = 3'b000;
  localparam logic [2:0] sll_funct3  = 3'b001;
  localparam logic [2:0] slt_funct3  = 3'b010;
  localparam logic [2:0] sltu_funct3 = 3'b011;
  localparam logic [2:0] xor_funct3  = 3'b100;
  localparam logic [2:0] sr_funct3   = 3'b101;
  localparam logic [2:0] or_funct3   = 3'b110;
  localparam logic [2:0] and_funct3  = 3'b111;

  // alu ops take the funct3 value where the two line up
  // sub and sra take the slots left free by slt and sltu
  typedef enum logic [2:0] {
    add_alu_op = 3'b000,
    sll_alu_op = 3'b001,
    sub_alu_op = 3'b010,
    sra_alu_op = 3'b011,
    xor_alu_op = 3'b100,
    srl_alu_op = 3'b101,
    or_alu_op  = 3'b110,
    and_alu_op = 3'b111
  } alu_op_t;

  // compare ops use the branch funct3 encoding
  typedef enum logic [2:0] {
    blt_cmp_op  = 3'b100,
    bltu_cmp_op = 3'b110
  } cmp_op_t;

  // one execute op word, read by alu or comparator
  typedef union packed {
    alu_op_t alu;
    cmp_op_t cmp;
  } exe_op_u;

endpackage
